//--- src/mfOutputIf.sv
`timescale 1ns/100ps
`default_nettype none

interface mfOutputIf;

    import soqpskPkg::*;

    // plus filter, real and imaginary
    sampleT ipOut;
    sampleT qpOut;

    // zero filter
    sampleT izOut;
    sampleT qzOut;

    // minus filter
    sampleT imOut;
    sampleT qmOut;

    // filter side
    modport src (
        output ipOut, output qpOut,
        output izOut, output qzOut,
        output imOut, output qmOut
    );

    // decision side, and the top level taps the same signals
    modport sink (
        input ipOut, input qpOut,
        input izOut, input qzOut,
        input imOut, input qmOut
    );

endinterface

`default_nettype wire

//--- src/mfSampleIf.sv
`timescale 1ns/100ps
`default_nettype none

interface mfSampleIf;

    import soqpskPkg::*;

    // recovered baseband samples, two per symbol
    sampleT iIn;
    sampleT qIn;

    // one-cycle strobes
    // symEn only ever rises together with sym2xEn
    logic   sym2xEn;
    logic   symEn;

    // filter consumes the samples on each sample strobe
    modport filt (input iIn, input qIn, input sym2xEn);

    // decision only needs the symbol strobe
    modport dec (input symEn);

endinterface

`default_nettype wire

//--- src/soqpsk2TapMf.sv
`timescale 1ns/100ps
`default_nettype none

module soqpsk2TapMf #(
    parameter soqpskPkg::sampleT ACOEF = soqpskPkg::defaultAcoef,
    parameter soqpskPkg::sampleT BCOEF = soqpskPkg::defaultBcoef,
    parameter soqpskPkg::sampleT CCOEF = soqpskPkg::defaultCcoef
) (
    input  logic         clk,
    input  logic         reset,
    mfSampleIf.filt      smp,
    mfOutputIf.src       mf
);

    import soqpskPkg::*;

    // two-tap filters at one sample per bit
    // every tap weight is A or B, so with one sample of delay
    //   plus  = (I0+jQ0)(A+jB) + (I1+jQ1)(A-jB)
    //   minus = (I0+jQ0)(B+jA) - (I1+jQ1)(B-jA)
    // reduce to four cross sums of the products

    // registered products of the newest sample
    productT iaProd;
    productT ibProd;
    productT qaProd;
    productT qbProd;

    // cross sums, current stage
    productT sum0;
    productT sum1;
    productT sum2;
    productT sum3;

    // cross sums, one sample back
    productT sum0Dly;
    productT sum1Dly;
    productT sum2Dly;
    productT sum3Dly;

    // plus and minus accumulators
    productT pReal;
    productT pImag;
    productT mReal;
    productT mImag;

    // zero filter terms, both taps weighted 1/sqrt(2)
    productT iScaled;
    productT qScaled;
    productT zSum;
    productT zDiff;
    productT zSumDly;
    productT zDiffDly;
    productT zReal;
    productT zImag;

    // sum0 = IA - QB, sum1 = IB + QA
    assign sum0 = iaProd - qbProd;
    assign sum1 = ibProd + qaProd;
    // sum2 = IA + QB, sum3 = IB - QA
    assign sum2 = iaProd + qbProd;
    assign sum3 = ibProd - qaProd;

    // I+Q and I-Q of the scaled sample
    assign zSum  = iScaled + qScaled;
    assign zDiff = iScaled - qScaled;

    // datapath runs free, only the sample strobe advances it
    always_ff @(posedge clk) begin
        if (smp.sym2xEn) begin
            // 18x18 signed products, full 36-bit result
            iaProd <= smp.iIn * ACOEF;
            ibProd <= smp.iIn * BCOEF;
            qaProd <= smp.qIn * ACOEF;
            qbProd <= smp.qIn * BCOEF;
            iScaled <= smp.iIn * CCOEF;
            qScaled <= smp.qIn * CCOEF;

            // delay line, one sample
            sum0Dly <= sum0;
            sum1Dly <= sum1;
            sum2Dly <= sum2;
            sum3Dly <= sum3;
            zSumDly  <= zSum;
            zDiffDly <= zDiff;

            // reversed tap order, normal phase
            pReal <= sum2 + sum0Dly;
            pImag <= sum1Dly - sum3;
            mReal <= sum3Dly - sum1;
            mImag <= sum0 + sum2Dly;

            // zero = [(I0-Q0)+(I1-Q1)] + j[(I0+Q0)+(I1+Q1)], scaled
            zReal <= zDiff + zDiffDly;
            zImag <= zSum + zSumDly;
        end
    end

    // keep the upper 18 bits, no rounding or saturation
    assign mf.ipOut = sampleT'(pReal[35:18]);
    assign mf.qpOut = sampleT'(pImag[35:18]);
    assign mf.imOut = sampleT'(mReal[35:18]);
    assign mf.qmOut = sampleT'(mImag[35:18]);
    assign mf.izOut = sampleT'(zReal[35:18]);
    assign mf.qzOut = sampleT'(zImag[35:18]);

endmodule

`default_nettype wire

//--- src/soqpskDetector.sv
`timescale 1ns/100ps
`default_nettype none

module soqpskDetector #(
    parameter soqpskPkg::sampleT ACOEF = soqpskPkg::defaultAcoef,
    parameter soqpskPkg::sampleT BCOEF = soqpskPkg::defaultBcoef,
    parameter soqpskPkg::sampleT CCOEF = soqpskPkg::defaultCcoef
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               sym2xEn,
    input  logic               symEn,
    input  soqpskPkg::sampleT  iIn,
    input  soqpskPkg::sampleT  qIn,
    output soqpskPkg::sampleT  ipOut,
    output soqpskPkg::sampleT  qpOut,
    output soqpskPkg::sampleT  izOut,
    output soqpskPkg::sampleT  qzOut,
    output soqpskPkg::sampleT  imOut,
    output soqpskPkg::sampleT  qmOut,
    output soqpskPkg::ternaryT symbol,
    output logic               dataBit,
    output logic               symValid
);

    // samples and strobes in
    mfSampleIf smp ();
    // filter outputs to the decision
    mfOutputIf mf ();

    assign smp.iIn     = iIn;
    assign smp.qIn     = qIn;
    assign smp.sym2xEn = sym2xEn;
    assign smp.symEn   = symEn;

    // matched filters
    soqpsk2TapMf #(
        .ACOEF (ACOEF),
        .BCOEF (BCOEF),
        .CCOEF (CCOEF)
    ) mfBank (
        .clk   (clk),
        .reset (reset),
        .smp   (smp),
        .mf    (mf)
    );

    // symbol decision and bit mapping
    ternaryDecision decide (
        .clk      (clk),
        .reset    (reset),
        .smp      (smp),
        .mf       (mf),
        .symbol   (symbol),
        .dataBit  (dataBit),
        .symValid (symValid)
    );

    // filter outputs also leave the chip
    assign ipOut = mf.ipOut;
    assign qpOut = mf.qpOut;
    assign izOut = mf.izOut;
    assign qzOut = mf.qzOut;
    assign imOut = mf.imOut;
    assign qmOut = mf.qmOut;

endmodule

`default_nettype wire

//--- src/soqpskPkg.sv
`default_nettype none

package soqpskPkg;

    // one signed 18-bit complex component
    // used for input samples and filter outputs alike
    typedef logic signed [17:0] sampleT;

    // full-precision product or partial sum in the filter
    typedef logic signed [35:0] productT;

    // ternary symbol code
    typedef logic [1:0] ternaryT;

    // symbol codes, zero first so a cleared register reads as zero
    localparam ternaryT SYM_ZERO  = 2'b00;
    localparam ternaryT SYM_PLUS  = 2'b01;
    localparam ternaryT SYM_MINUS = 2'b10;

    // matched filter tap weights in Q1.17
    // A is cos(pi/8)/sqrt(2)
    localparam sampleT defaultAcoef = 18'sd85627;
    // B is sin(pi/8)/sqrt(2)
    localparam sampleT defaultBcoef = 18'sd35468;
    // zero filter weight, 1/sqrt(2)
    localparam sampleT defaultCcoef = 18'sd92682;

endpackage

`default_nettype wire

//--- src/ternaryDecision.sv
`timescale 1ns/100ps
`default_nettype none

module ternaryDecision (
    input  logic               clk,
    input  logic               reset,
    mfSampleIf.dec             smp,
    mfOutputIf.sink            mf,
    output soqpskPkg::ternaryT symbol,
    output logic               dataBit,
    output logic               symValid
);

    import soqpskPkg::*;

    // combinational choice from the current filter outputs
    ternaryT nextSymbol;
    logic    nextBit;

    // metrics are the in-phase outputs only
    // zero wins every tie, plus wins a tie with minus
    always_comb begin
        if ((mf.izOut >= mf.ipOut) && (mf.izOut >= mf.imOut)) begin
            nextSymbol = SYM_ZERO;
        end else if (mf.ipOut >= mf.imOut) begin
            nextSymbol = SYM_PLUS;
        end else begin
            nextSymbol = SYM_MINUS;
        end
    end

    // plus -> 1, minus -> 0
    // zero carries the last bit forward
    always_comb begin
        case (nextSymbol)
            SYM_PLUS: begin
                nextBit = 1'b1;
            end
            SYM_MINUS: begin
                nextBit = 1'b0;
            end
            default: begin
                nextBit = dataBit;
            end
        endcase
    end

    // decision taken from outputs as they stand on the strobe clock,
    // the filter update on that same edge shows up next symbol
    always_ff @(posedge clk) begin
        if (reset) begin
            symbol  <= SYM_ZERO;
            dataBit <= 1'b0;
        end else if (smp.symEn) begin
            symbol  <= nextSymbol;
            // dataBit doubles as the previous-bit state
            dataBit <= nextBit;
        end
    end

    // one-cycle valid right after each symbol strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            symValid <= 1'b0;
        end else begin
            symValid <= smp.symEn;
        end
    end

endmodule

`default_nettype wire

//--- verification/soqpskDetectorTb.sv
`timescale 1ns/100ps
`default_nettype none

module soqpskDetectorTb;

    import soqpskPkg::*;

    localparam integer PERIOD      = 100;
    localparam integer RESETCYCLES = 16;
    localparam integer DRIVEDELAY  = 10;
    localparam integer NUMFIELDS   = 13;

    // DUT inputs
    logic    clk;
    logic    reset;
    logic    sym2xEn;
    logic    symEn;
    sampleT  iIn;
    sampleT  qIn;

    // DUT outputs
    sampleT  ipOut;
    sampleT  qpOut;
    sampleT  izOut;
    sampleT  qzOut;
    sampleT  imOut;
    sampleT  qmOut;
    ternaryT symbol;
    logic    dataBit;
    logic    symValid;

    // data file state
    integer  fd;
    integer  lineCount;
    logic    countReady;
    reg [8*256-1:0] lineBuf;

    // fields of the current line, and expected values of the previous one
    integer  fld [0:NUMFIELDS-1];
    integer  expd [0:NUMFIELDS-1];

    soqpskDetector u_dut (
        .clk      (clk),
        .reset    (reset),
        .sym2xEn  (sym2xEn),
        .symEn    (symEn),
        .iIn      (iIn),
        .qIn      (qIn),
        .ipOut    (ipOut),
        .qpOut    (qpOut),
        .izOut    (izOut),
        .qzOut    (qzOut),
        .imOut    (imOut),
        .qmOut    (qmOut),
        .symbol   (symbol),
        .dataBit  (dataBit),
        .symValid (symValid)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // failure that is not a value mismatch
    task automatic abortRun(input string why);
        begin
            $display("%s", why);
            $display("test failed");
            $fatal(1, "run aborted");
        end
    endtask

    // compare one value and stop at the first mismatch
    task automatic checkValue(input string name, input integer actual, input integer expected);
        begin
            if (actual !== expected) begin
                $display("Error at %0d ns: %s is %0d, expected %0d",
                         $time, name, actual, expected);
                $display("test failed");
                $fatal(1, "mismatch on %s", name);
            end
        end
    endtask

    // count the data lines and skip comment lines
    task automatic countDataLines(output integer total);
        integer cfd;
        integer tmp;
        begin
            total = 0;
            cfd = $fopen("verification/soqpsk_testdata.txt", "r");
            if (cfd == 0) begin
                abortRun("could not open the data file verification/soqpsk_testdata.txt");
            end
            while ($fgets(lineBuf, cfd) != 0) begin
                if ($sscanf(lineBuf, "%d", tmp) == 1) begin
                    total = total + 1;
                end
            end
            $fclose(cfd);
        end
    endtask

    // read the next line holding numbers into fld
    task automatic readDataLine(output integer found);
        integer got;
        integer done;
        begin
            found = 0;
            done = 0;
            while (!done) begin
                if ($fgets(lineBuf, fd) == 0) begin
                    done = 1;
                end else begin
                    got = $sscanf(lineBuf, "%d %d %d %d %d %d %d %d %d %d %d %d %d",
                                  fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                                  fld[7], fld[8], fld[9], fld[10], fld[11], fld[12]);
                    if (got == NUMFIELDS) begin
                        found = 1;
                        done = 1;
                    end else if (got > 0) begin
                        abortRun("a line of the data file has too few fields");
                    end
                end
            end
        end
    endtask

    // all outputs against the expected columns
    task automatic checkOutputs;
        begin
            checkValue("ipOut", ipOut, expd[4]);
            checkValue("qpOut", qpOut, expd[5]);
            checkValue("izOut", izOut, expd[6]);
            checkValue("qzOut", qzOut, expd[7]);
            checkValue("imOut", imOut, expd[8]);
            checkValue("qmOut", qmOut, expd[9]);
            checkValue("symbol", symbol, expd[10]);
            checkValue("dataBit", dataBit, expd[11]);
            checkValue("symValid", symValid, expd[12]);
        end
    endtask

    // decision side must be cleared while in reset
    task automatic checkResetState;
        begin
            checkValue("symValid", symValid, 0);
            checkValue("symbol", symbol, SYM_ZERO);
            checkValue("dataBit", dataBit, 0);
        end
    endtask

    // watchdog sized from the data file once it is counted
    initial begin
        wait (countReady === 1'b1);
        #((lineCount + RESETCYCLES + 20) * PERIOD);
        $display("watchdog expired before all data lines were checked");
        $display("test failed");
        $fatal(1, "timeout");
    end

    // stimulus and checking
    initial begin
        integer n;
        integer found;
        reset = 1'b1;
        sym2xEn = 1'b0;
        symEn = 1'b0;
        iIn = '0;
        qIn = '0;
        countReady = 1'b0;
        lineCount = 0;

        countDataLines(lineCount);
        if (lineCount == 0) begin
            abortRun("the data file holds no data lines");
        end
        fd = $fopen("verification/soqpsk_testdata.txt", "r");
        if (fd == 0) begin
            abortRun("could not reopen the data file");
        end
        countReady = 1'b1;

        // zero samples flush the unreset filter registers
        // symbol strobes on alternate samples must not reach the decision in reset
        for (n = 0; n < RESETCYCLES - 1; n = n + 1) begin
            @(posedge clk);
            #DRIVEDELAY;
            checkResetState();
            sym2xEn = 1'b1;
            symEn = ~n[0];
            iIn = '0;
            qIn = '0;
        end

        // each line's outputs are checked one clock after it is driven
        for (n = 0; n < lineCount; n = n + 1) begin
            readDataLine(found);
            if (!found) begin
                abortRun("the data file ended before all counted lines were read");
            end
            @(posedge clk);
            #DRIVEDELAY;
            if (n == 0) begin
                checkResetState();
            end else begin
                checkOutputs();
            end
            reset = 1'b0;
            sym2xEn = fld[0][0];
            symEn = fld[1][0];
            iIn = fld[2];
            qIn = fld[3];
            for (int k = 0; k < NUMFIELDS; k++) begin
                expd[k] = fld[k];
            end
        end

        // last line
        @(posedge clk);
        #DRIVEDELAY;
        checkOutputs();
        $fclose(fd);

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/soqpsk_testdata.txt
// sym2xEn symEn iIn qIn | expected after the edge: ipOut qpOut izOut qzOut imOut qmOut symbol bit symValid
// samples are multiples of 4096, idle clocks carry junk inputs that must be ignored
1 0 16384 0 0 0 0 0 0 0 0 0 0
0 0 777 -555 0 0 0 0 0 0 0 0 0
1 1 16384 0 5351 -2217 5792 5792 -2217 5351 0 0 1
0 0 777 -555 5351 -2217 5792 5792 -2217 5351 0 0 0
0 0 -999 321 5351 -2217 5792 5792 -2217 5351 0 0 0
0 0 777 -555 5351 -2217 5792 5792 -2217 5351 0 0 0
1 0 -16384 0 10703 0 11585 11585 0 10703 0 0 0
1 1 0 16384 0 4433 0 0 4433 0 0 0 1
0 0 777 -555 0 4433 0 0 4433 0 0 0 0
1 0 0 -16384 -3135 3134 -11586 0 -7569 -7569 0 0 0
0 0 -999 321 -3135 3134 -11586 0 -7569 -7569 0 0 0
1 1 -131072 0 -4434 0 0 0 0 4433 1 1 1
0 0 777 -555 -4434 0 0 0 0 4433 1 1 0
0 0 777 -555 -4434 0 0 0 0 4433 1 1 0
0 0 -999 321 -4434 0 0 0 0 4433 1 1 0
1 0 -131072 12288 -40597 12382 -40549 -52134 23085 -45031 1 1 0
0 0 777 -555 -40597 12382 -40549 -52134 23085 -45031 1 1 0
1 1 8192 -8192 -83965 4013 -97027 -88338 -4014 -87290 2 0 1
0 0 777 -555 -83965 4013 -97027 -88338 -4014 -87290 2 0 0
1 0 4096 4096 -42909 -17505 -44893 -41997 -20181 -37367 2 0 0
0 0 -999 321 -42909 -17505 -44893 -41997 -20181 -37367 2 0 0
0 0 777 -555 -42909 -17505 -44893 -41997 -20181 -37367 2 0 0
1 1 0 0 5676 -784 5792 2896 1892 2351 2 0 1
0 0 777 -555 5676 -784 5792 2896 1892 2351 2 0 0
1 0 0 0 783 1892 0 2896 -784 1892 2 0 0
0 0 -999 321 783 1892 0 2896 -784 1892 2 0 0
1 1 0 0 0 0 0 0 0 0 1 1 1
0 0 777 -555 0 0 0 0 0 0 1 1 0
1 0 0 0 0 0 0 0 0 0 1 1 0
0 0 777 -555 0 0 0 0 0 0 1 1 0
1 1 0 0 0 0 0 0 0 0 0 1 1
0 0 -999 321 0 0 0 0 0 0 0 1 0
0 0 777 -555 0 0 0 0 0 0 0 1 0

//--- verilog.f
src/soqpskPkg.sv
src/mfSampleIf.sv
src/mfOutputIf.sv
src/soqpsk2TapMf.sv
src/ternaryDecision.sv
src/soqpskDetector.sv
verification/soqpskDetectorTb.sv
